/* reg_board_pkg.sv */
// Register board shared definitions
// Widths, microcode field codes, register indices, CSR map and panel word view
package reg_board_pkg;

   localparam int DATA_W    = 16;          // Register and processor bus width
   localparam int NUM_REGS  = 4;           // PC, DR, AC, SP
   localparam int PC_PAGE_W = 6;           // PC bits 15:10 leave the board

   localparam logic [1:0] REG_PC = 2'd0;
   localparam logic [1:0] REG_DR = 2'd1;
   localparam logic [1:0] REG_AC = 2'd2;
   localparam logic [1:0] REG_SP = 2'd3;

   localparam int FIELD_EN_BIT  = 3;       // Field active when high
   localparam int FIELD_INH_BIT = 4;       // Field inhibited when high

   // Action codes, low three bits, valid with action bit 3 high
   localparam logic [2:0] ACT_INC_PC = 3'd0;
   localparam logic [2:0] ACT_INC_DR = 3'd2;
   localparam logic [2:0] ACT_DEC_DR = 3'd3;
   localparam logic [2:0] ACT_INC_AC = 3'd4;
   localparam logic [2:0] ACT_DEC_AC = 3'd5;
   localparam logic [2:0] ACT_INC_SP = 3'd6;
   localparam logic [2:0] ACT_DEC_SP = 3'd7;

   localparam int AXI_ADDR_W = 5;
   localparam int AXI_DATA_W = 32;

   localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

   //////////////////////////////////////////////////
   // CSR byte offsets
   //////////////////////////////////////////////////
   localparam logic [AXI_ADDR_W-1:0] CSR_PANEL_SEL = 5'h00;
   localparam logic [AXI_ADDR_W-1:0] CSR_DEPOSIT   = 5'h04;
   localparam logic [AXI_ADDR_W-1:0] CSR_PC        = 5'h08;
   localparam logic [AXI_ADDR_W-1:0] CSR_DR        = 5'h0C;
   localparam logic [AXI_ADDR_W-1:0] CSR_AC        = 5'h10;
   localparam logic [AXI_ADDR_W-1:0] CSR_SP        = 5'h14;

   typedef struct packed {
      logic [7:0] hi;                      // Front panel high byte
      logic [7:0] lo;                      // Front panel low byte
   } panel_bytes_t;

   // One register word, whole or as two byte lanes
   typedef union packed {
      logic [DATA_W-1:0] word;
      panel_bytes_t      bytes;
   } panel_word_u;

endpackage

/* field_decoder.sv */
// Microcode field decoder
// Turns raddr, waddr and action into per-register read, write, inc and dec strobes
`timescale 1ns/100ps

module field_decoder (
   input  logic [4:0]                         raddr,
   input  logic [4:0]                         waddr,
   input  logic [3:0]                         action,
   output logic [reg_board_pkg::NUM_REGS-1:0] rd_sel,
   output logic [reg_board_pkg::NUM_REGS-1:0] wr_stb,
   output logic [reg_board_pkg::NUM_REGS-1:0] inc_stb,
   output logic [reg_board_pkg::NUM_REGS-1:0] dec_stb
);
   import reg_board_pkg::*;

   // Read and write address fields share one decode
   function automatic logic [NUM_REGS-1:0] addr_decode(input logic [4:0] field);
      logic [NUM_REGS-1:0] sel;
      sel = '0;
      if (field[FIELD_EN_BIT] && !field[FIELD_INH_BIT]) begin
         case (field[2:0])
            {1'b0, REG_PC}: sel[REG_PC] = 1'b1;
            {1'b0, REG_DR}: sel[REG_DR] = 1'b1;
            {1'b0, REG_AC}: sel[REG_AC] = 1'b1;
            {1'b0, REG_SP}: sel[REG_SP] = 1'b1;
            default:        sel = '0;         // Codes 4..7 belong to other boards
         endcase
      end
      return sel;
   endfunction

   //////////////////////////////////////////////////
   // Read and write address decode
   //////////////////////////////////////////////////
   assign rd_sel = addr_decode(raddr);
   assign wr_stb = addr_decode(waddr);

   //////////////////////////////////////////////////
   // Action decode
   //////////////////////////////////////////////////
   always_comb begin
      inc_stb = '0;
      dec_stb = '0;
      if (action[FIELD_EN_BIT]) begin      // No inhibit bit on this field
         case (action[2:0])
            ACT_INC_PC: inc_stb[REG_PC] = 1'b1;
            ACT_INC_DR: inc_stb[REG_DR] = 1'b1;
            ACT_DEC_DR: dec_stb[REG_DR] = 1'b1;
            ACT_INC_AC: inc_stb[REG_AC] = 1'b1;
            ACT_DEC_AC: dec_stb[REG_AC] = 1'b1;
            ACT_INC_SP: inc_stb[REG_SP] = 1'b1;
            ACT_DEC_SP: dec_stb[REG_SP] = 1'b1;
            default:    inc_stb = '0;     // Code 1 unused here
         endcase
      end
   end

endmodule

/* major_register.sv */
// Major register
// 16-bit register with bus load, inc/dec, front-panel deposit and flags
`timescale 1ns/100ps

module major_register (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [reg_board_pkg::DATA_W-1:0] ibus_in,
   input  logic                             wr_stb,
   input  logic                             inc_stb,
   input  logic                             dec_stb,
   input  logic                             dep_req,
   input  logic [reg_board_pkg::DATA_W-1:0] dep_data,
   output logic                             dep_ack,
   output logic [reg_board_pkg::DATA_W-1:0] value,
   output logic                             zero,
   output logic                             neg
);
   import reg_board_pkg::*;

   logic dep_take;                         // Deposit lands this cycle

   // Microcode always wins; a deposit waits for a quiet cycle
   assign dep_take = dep_req && !dep_ack && !(wr_stb || inc_stb || dec_stb);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         value   <= '0;
         dep_ack <= 1'b0;
      end else begin
         dep_ack <= dep_take;              // One-cycle ack pulse
         if (wr_stb) begin
            value <= ibus_in;              // Bus load beats inc/dec
         end else if (inc_stb) begin
            value <= value + 1'b1;         // Wraps at 16 bits
         end else if (dec_stb) begin
            value <= value - 1'b1;
         end else if (dep_take) begin
            value <= dep_data;
         end
      end
   end

   //////////////////////////////////////////////////
   // Flags
   //////////////////////////////////////////////////
   assign zero = (value == '0);
   assign neg  = value[DATA_W-1];          // Sign bit

endmodule

/* panel_mux.sv */
// Panel and bus read mux
// Drives the processor bus from the read-selected register and the panel byte
`timescale 1ns/100ps

module panel_mux (
   input  logic [reg_board_pkg::DATA_W-1:0]   pc,
   input  logic [reg_board_pkg::DATA_W-1:0]   dr,
   input  logic [reg_board_pkg::DATA_W-1:0]   ac,
   input  logic [reg_board_pkg::DATA_W-1:0]   sp,
   input  logic [reg_board_pkg::NUM_REGS-1:0] rd_sel,
   input  logic [1:0]                         panel_reg,
   input  logic                               panel_hi,
   output logic [reg_board_pkg::DATA_W-1:0]   ibus_out,
   output logic                               ibus_drive,
   output logic [7:0]                         fpd
);
   import reg_board_pkg::*;

   panel_word_u panel_word;                // Register shown on the panel

   // rd_sel is one-hot, so an AND-OR mux is enough
   assign ibus_out = ({DATA_W{rd_sel[REG_PC]}} & pc)
                   | ({DATA_W{rd_sel[REG_DR]}} & dr)
                   | ({DATA_W{rd_sel[REG_AC]}} & ac)
                   | ({DATA_W{rd_sel[REG_SP]}} & sp);
   assign ibus_drive = |rd_sel;            // Replaces the tri-state enable

   always_comb begin
      case (panel_reg)
         REG_PC:  panel_word.word = pc;
         REG_DR:  panel_word.word = dr;
         REG_AC:  panel_word.word = ac;
         default: panel_word.word = sp;
      endcase
   end

   assign fpd = panel_hi ? panel_word.bytes.hi : panel_word.bytes.lo;

endmodule

/* panel_csr.sv */
// Front-panel configuration block
// AXI4-Lite slave for panel select, register deposit and register readback
`timescale 1ns/100ps

module panel_csr (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [reg_board_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
   input  logic                                 s_axi_awvalid,
   output logic                                 s_axi_awready,
   input  logic [reg_board_pkg::AXI_DATA_W-1:0] s_axi_wdata,
   input  logic [3:0]                           s_axi_wstrb,
   input  logic                                 s_axi_wvalid,
   output logic                                 s_axi_wready,
   output logic [1:0]                           s_axi_bresp,
   output logic                                 s_axi_bvalid,
   input  logic                                 s_axi_bready,
   input  logic [reg_board_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
   input  logic                                 s_axi_arvalid,
   output logic                                 s_axi_arready,
   output logic [reg_board_pkg::AXI_DATA_W-1:0] s_axi_rdata,
   output logic [1:0]                           s_axi_rresp,
   output logic                                 s_axi_rvalid,
   input  logic                                 s_axi_rready,
   input  logic [reg_board_pkg::DATA_W-1:0]     pc,
   input  logic [reg_board_pkg::DATA_W-1:0]     dr,
   input  logic [reg_board_pkg::DATA_W-1:0]     ac,
   input  logic [reg_board_pkg::DATA_W-1:0]     sp,
   input  logic [reg_board_pkg::NUM_REGS-1:0]   dep_ack,
   output logic [reg_board_pkg::NUM_REGS-1:0]   dep_req,
   output logic [reg_board_pkg::DATA_W-1:0]     dep_data,
   output logic [1:0]                           panel_reg,
   output logic                                 panel_hi
);
   import reg_board_pkg::*;

   logic                  dep_pending;     // Deposit waiting for its register
   logic [1:0]            dep_idx;         // Last deposit target
   panel_word_u           rd_word;         // Live register for readback
   logic [AXI_DATA_W-1:0] rd_data;

   assign dep_pending = |dep_req;

   //////////////////////////////////////////////////
   // Write channel
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_awready <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
         s_axi_bresp   <= AXI_RESP_OKAY;
         panel_reg     <= REG_PC;
         panel_hi      <= 1'b0;
         dep_req       <= '0;
         dep_idx       <= REG_PC;
         dep_data      <= '0;
      end else begin
         dep_req <= dep_req & ~dep_ack;    // Drop request once acked
         if (s_axi_bvalid && s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
         end
         if (s_axi_awready) begin          // Address and data handshake
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b1;
            s_axi_bresp   <= AXI_RESP_OKAY;
            case (s_axi_awaddr)
               CSR_PANEL_SEL: begin
                  if (s_axi_wstrb[0]) begin
                     panel_reg <= s_axi_wdata[1:0];
                     panel_hi  <= s_axi_wdata[2];
                  end
               end
               CSR_DEPOSIT: begin
                  if (dep_pending) begin
                     s_axi_bresp <= AXI_RESP_SLVERR;  // Busy, write dropped
                  end else if (&s_axi_wstrb[2:0]) begin
                     dep_idx  <= s_axi_wdata[17:16];
                     dep_data <= s_axi_wdata[DATA_W-1:0];
                     dep_req  <= NUM_REGS'(1) << s_axi_wdata[17:16];
                  end
               end
               default: ;                  // Readback and unmapped ignore writes
            endcase
         end else if (s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Read channel
   //////////////////////////////////////////////////
   always_comb begin
      rd_word.word = '0;
      rd_data      = '0;
      case (s_axi_araddr)
         CSR_PANEL_SEL: rd_data = {29'b0, panel_hi, panel_reg};
         CSR_DEPOSIT:   rd_data = {dep_pending, 13'b0, dep_idx, dep_data};
         CSR_PC:        rd_word.word = pc;
         CSR_DR:        rd_word.word = dr;
         CSR_AC:        rd_word.word = ac;
         CSR_SP:        rd_word.word = sp;
         default:       rd_data = '0;      // Unmapped reads as zero
      endcase
      rd_data = rd_data | {16'b0, rd_word.bytes.hi, rd_word.bytes.lo};
   end

   assign s_axi_rresp = AXI_RESP_OKAY;     // Reads never fail

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axi_arready <= 1'b0;
         s_axi_rvalid  <= 1'b0;
         s_axi_rdata   <= '0;
      end else begin
         if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
         end
         if (s_axi_arready) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b1;
            s_axi_rdata   <= rd_data;      // Sampled at the handshake
         end else if (s_axi_arvalid && !s_axi_rvalid) begin
            s_axi_arready <= 1'b1;
         end
      end
   end

endmodule

/* reg_board_top.sv */
// Register board top level
// Field decoder, PC/DR/AC/SP major registers, panel mux and AXI4-Lite CSR block
`timescale 1ns/100ps

module reg_board_top (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [4:0]                           raddr,
   input  logic [4:0]                           waddr,
   input  logic [3:0]                           action,
   input  logic [reg_board_pkg::DATA_W-1:0]     ibus_in,
   output logic [reg_board_pkg::DATA_W-1:0]     ibus_out,
   output logic                                 ibus_drive,
   output logic [reg_board_pkg::PC_PAGE_W-1:0]  pc_page,
   output logic [reg_board_pkg::DATA_W-1:0]     ac,
   output logic                                 fz,
   output logic                                 ac_neg,
   output logic [7:0]                           fpd,
   input  logic [reg_board_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
   input  logic                                 s_axi_awvalid,
   output logic                                 s_axi_awready,
   input  logic [reg_board_pkg::AXI_DATA_W-1:0] s_axi_wdata,
   input  logic [3:0]                           s_axi_wstrb,
   input  logic                                 s_axi_wvalid,
   output logic                                 s_axi_wready,
   output logic [1:0]                           s_axi_bresp,
   output logic                                 s_axi_bvalid,
   input  logic                                 s_axi_bready,
   input  logic [reg_board_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
   input  logic                                 s_axi_arvalid,
   output logic                                 s_axi_arready,
   output logic [reg_board_pkg::AXI_DATA_W-1:0] s_axi_rdata,
   output logic [1:0]                           s_axi_rresp,
   output logic                                 s_axi_rvalid,
   input  logic                                 s_axi_rready
);
   import reg_board_pkg::*;

   logic [NUM_REGS-1:0] rd_sel, wr_stb, inc_stb, dec_stb;
   logic [NUM_REGS-1:0] dep_req, dep_ack;
   logic [DATA_W-1:0]   dep_data;
   logic [DATA_W-1:0]   pc, dr, sp;        // AC leaves the board directly
   logic [1:0]          panel_reg;
   logic                panel_hi;

   assign pc_page = pc[DATA_W-1 -: PC_PAGE_W];  // PC bits 15:10

   field_decoder u_decoder (.raddr(raddr), .waddr(waddr), .action(action),
      .rd_sel(rd_sel), .wr_stb(wr_stb), .inc_stb(inc_stb), .dec_stb(dec_stb));

   //////////////////////////////////////////////////
   // The four major registers
   //////////////////////////////////////////////////
   major_register reg_pc (.clk(clk), .rst_n(rst_n), .ibus_in(ibus_in),
      .wr_stb(wr_stb[REG_PC]), .inc_stb(inc_stb[REG_PC]), .dec_stb(dec_stb[REG_PC]),
      .dep_req(dep_req[REG_PC]), .dep_data(dep_data), .dep_ack(dep_ack[REG_PC]),
      .value(pc), .zero(), .neg());
   major_register reg_dr (.clk(clk), .rst_n(rst_n), .ibus_in(ibus_in),
      .wr_stb(wr_stb[REG_DR]), .inc_stb(inc_stb[REG_DR]), .dec_stb(dec_stb[REG_DR]),
      .dep_req(dep_req[REG_DR]), .dep_data(dep_data), .dep_ack(dep_ack[REG_DR]),
      .value(dr), .zero(), .neg());
   major_register reg_ac (.clk(clk), .rst_n(rst_n), .ibus_in(ibus_in),
      .wr_stb(wr_stb[REG_AC]), .inc_stb(inc_stb[REG_AC]), .dec_stb(dec_stb[REG_AC]),
      .dep_req(dep_req[REG_AC]), .dep_data(dep_data), .dep_ack(dep_ack[REG_AC]),
      .value(ac), .zero(fz), .neg(ac_neg));   // Only AC flags are exported
   major_register reg_sp (.clk(clk), .rst_n(rst_n), .ibus_in(ibus_in),
      .wr_stb(wr_stb[REG_SP]), .inc_stb(inc_stb[REG_SP]), .dec_stb(dec_stb[REG_SP]),
      .dep_req(dep_req[REG_SP]), .dep_data(dep_data), .dep_ack(dep_ack[REG_SP]),
      .value(sp), .zero(), .neg());

   panel_mux u_panel_mux (.pc(pc), .dr(dr), .ac(ac), .sp(sp), .rd_sel(rd_sel),
      .panel_reg(panel_reg), .panel_hi(panel_hi),
      .ibus_out(ibus_out), .ibus_drive(ibus_drive), .fpd(fpd));

   //////////////////////////////////////////////////
   // Host configuration block
   //////////////////////////////////////////////////
   panel_csr u_csr (.clk(clk), .rst_n(rst_n),
      .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
      .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
      .s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid),
      .s_axi_wready(s_axi_wready), .s_axi_bresp(s_axi_bresp),
      .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
      .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
      .s_axi_arready(s_axi_arready), .s_axi_rdata(s_axi_rdata),
      .s_axi_rresp(s_axi_rresp), .s_axi_rvalid(s_axi_rvalid),
      .s_axi_rready(s_axi_rready),
      .pc(pc), .dr(dr), .ac(ac), .sp(sp), .dep_ack(dep_ack),
      .dep_req(dep_req), .dep_data(dep_data),
      .panel_reg(panel_reg), .panel_hi(panel_hi));

endmodule

/* tb_reg_board.sv */
// Register board testbench
// Table-driven microcode steps against a register model, plus AXI4-Lite panel,
// deposit and readback checks
`timescale 1ns/100ps

module tb_reg_board;
   import reg_board_pkg::*;

   localparam int TIMEOUT   = 50;          // Cycles or polls allowed per wait
   localparam int MAX_STEPS = 80;

   typedef struct packed {
      logic [4:0]  raddr;
      logic [4:0]  waddr;
      logic [3:0]  action;
      logic [15:0] ibus_in;
      logic [15:0] exp_bus;                // Bus value before the edge
      logic        exp_drive;
      logic [5:0]  exp_page;               // Flop outputs after the edge
      logic [15:0] exp_ac;
      logic        exp_fz;
      logic        exp_neg;
   } step_t;

   logic clk, rst_n, ibus_drive, fz, ac_neg;
   logic [4:0] raddr, waddr;
   logic [3:0] action;
   logic [DATA_W-1:0] ibus_in, ibus_out, ac;
   logic [PC_PAGE_W-1:0] pc_page;
   logic [7:0] fpd;
   logic [AXI_ADDR_W-1:0] s_axi_awaddr, s_axi_araddr;
   logic [AXI_DATA_W-1:0] s_axi_wdata, s_axi_rdata;
   logic [3:0] s_axi_wstrb;
   logic [1:0] s_axi_bresp, s_axi_rresp;
   logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid;
   logic s_axi_bready, s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;

   logic [31:0] lfsr_state;
   logic [15:0] model [0:NUM_REGS-1];      // Expected PC, DR, AC, SP
   step_t       steps [0:MAX_STEPS-1];
   int          num_steps;

   reg_board_top dut (.*);

   always #5 clk = ~clk;                   // 10 ns period

   task automatic fail_now(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                            $time, name, got, exp));
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic next_bit();
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      return lfsr_state[0];
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], next_bit()};       // One step per bit
      end
      return v;
   endfunction

   // Register index of an active field, -1 when idle or for another board
   function automatic int field_target(input logic [4:0] f);
      if (f[3] && !f[4] && !f[2]) return int'(f[1:0]);
      return -1;
   endfunction

   //////////////////////////////////////////////////
   // Microcode table
   //////////////////////////////////////////////////
   task automatic add_step(input logic [4:0] ra, input logic [4:0] wa,
                           input logic [3:0] act, input logic [15:0] data);
      step_t s;
      int rt;
      int wt;
      rt          = field_target(ra);
      wt          = field_target(wa);
      s.raddr     = ra;
      s.waddr     = wa;
      s.action    = act;
      s.ibus_in   = data;
      s.exp_drive = (rt >= 0);
      s.exp_bus   = (rt >= 0) ? model[rt] : 16'h0;
      if (act[3]) begin
         case (act[2:0])
            ACT_INC_PC: model[REG_PC] = model[REG_PC] + 16'd1;
            ACT_INC_DR: model[REG_DR] = model[REG_DR] + 16'd1;
            ACT_DEC_DR: model[REG_DR] = model[REG_DR] - 16'd1;
            ACT_INC_AC: model[REG_AC] = model[REG_AC] + 16'd1;
            ACT_DEC_AC: model[REG_AC] = model[REG_AC] - 16'd1;
            ACT_INC_SP: model[REG_SP] = model[REG_SP] + 16'd1;
            ACT_DEC_SP: model[REG_SP] = model[REG_SP] - 16'd1;
            default: ;                     // Code 1 does nothing
         endcase
      end
      if (wt >= 0) model[wt] = data;       // Write beats the action
      s.exp_page = model[REG_PC][15:10];
      s.exp_ac   = model[REG_AC];
      s.exp_fz   = (model[REG_AC] == 16'h0);
      s.exp_neg  = model[REG_AC][15];
      steps[num_steps] = s;
      num_steps++;
   endtask

   task automatic build_table();
      logic [15:0] bits;
      for (int r = 0; r < NUM_REGS; r++) begin
         add_step(5'b0, {3'b010, r[1:0]}, 4'h0, rand_bits(16));   // Bus write
         add_step({3'b010, r[1:0]}, 5'b0, 4'h0, rand_bits(16));   // Bus read
         add_step({3'b110, r[1:0]}, {3'b110, r[1:0]}, 4'h0, rand_bits(16));  // Inhibited
         add_step({3'b000, r[1:0]}, {3'b000, r[1:0]}, 4'h0, rand_bits(16));  // Not enabled
         add_step({2'b01, 1'b1, r[1:0]}, {2'b01, 1'b1, r[1:0]}, 4'h0, rand_bits(16));
      end
      for (int r = 0; r < 8; r++) begin
         add_step(5'b0, 5'b0, {1'b1, r[2:0]}, rand_bits(16));
         add_step({3'b010, r[1:0]}, 5'b0, {1'b0, r[2:0]}, rand_bits(16));  // Action off
      end
      add_step(5'b0, 5'b01001, 4'h0, 16'hFFFF);              // DR wraps up then down
      add_step(5'b0, 5'b0, {1'b1, ACT_INC_DR}, 16'h0);
      add_step(5'b0, 5'b0, {1'b1, ACT_DEC_DR}, 16'h0);
      add_step(5'b0, 5'b01010, 4'h0, 16'h0);
      add_step(5'b0, 5'b0, {1'b1, ACT_DEC_AC}, 16'h0);       // AC negative
      add_step(5'b0, 5'b0, {1'b1, ACT_INC_AC}, 16'h0);
      add_step(5'b0, 5'b01011, 4'h0, 16'hFFFF);
      add_step(5'b0, 5'b0, {1'b1, ACT_INC_SP}, 16'h0);
      add_step(5'b0, 5'b0, {1'b1, ACT_DEC_SP}, 16'h0);
      add_step(5'b0, 5'b01000, 4'h0, 16'hFFFF);              // PC page all ones
      add_step(5'b01000, 5'b0, {1'b1, ACT_INC_PC}, 16'h0);
      add_step(5'b01010, 5'b01010, {1'b1, ACT_INC_AC}, rand_bits(16));
      add_step(5'b01001, 5'b01011, {1'b1, ACT_DEC_DR}, rand_bits(16));
      for (int r = 0; r < 14; r++) begin
         bits = rand_bits(14);
         add_step(bits[4:0], bits[9:5], bits[13:10], rand_bits(16));
      end
   endtask

   task automatic run_table();
      @(posedge clk);
      #1;
      for (int i = 0; i < num_steps; i++) begin
         raddr   = steps[i].raddr;
         waddr   = steps[i].waddr;
         action  = steps[i].action;
         ibus_in = steps[i].ibus_in;
         #4;                               // Mid-cycle, bus read settled
         check("ibus_drive", ibus_drive, steps[i].exp_drive);
         if (steps[i].exp_drive) check("ibus_out", ibus_out, steps[i].exp_bus);
         @(posedge clk);
         #1;
         check("pc_page", pc_page, steps[i].exp_page);
         check("ac", ac, steps[i].exp_ac);
         check("fz", fz, steps[i].exp_fz);
         check("ac_neg", ac_neg, steps[i].exp_neg);
      end
      raddr  = 5'b0;                       // Idle before the next edge
      waddr  = 5'b0;
      action = 4'h0;
   endtask

   //////////////////////////////////////////////////
   // AXI4-Lite host
   //////////////////////////////////////////////////
   task automatic write_csr(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      @(posedge clk);
      #1;
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_wstrb   = 4'hF;
      s_axi_awvalid = 1'b1;
      s_axi_wvalid  = 1'b1;
      for (n = 0; !s_axi_awready; n++) begin
         if (n == TIMEOUT) fail_now("timeout waiting for awready on a CSR write");
         @(posedge clk);
         #1;
      end
      check("s_axi_wready", s_axi_wready, 1'b1);
      @(posedge clk);                      // Address and data taken here
      #1;
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b1;
      for (n = 0; !s_axi_bvalid; n++) begin
         if (n == TIMEOUT) fail_now("timeout waiting for bvalid on a CSR write");
         @(posedge clk);
         #1;
      end
      resp = s_axi_bresp;
      @(posedge clk);
      #1;
      s_axi_bready = 1'b0;
   endtask

   task automatic read_csr(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int n;
      @(posedge clk);
      #1;
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      for (n = 0; !s_axi_arready; n++) begin
         if (n == TIMEOUT) fail_now("timeout waiting for arready on a CSR read");
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b1;
      for (n = 0; !s_axi_rvalid; n++) begin
         if (n == TIMEOUT) fail_now("timeout waiting for rvalid on a CSR read");
         @(posedge clk);
         #1;
      end
      data = s_axi_rdata;
      resp = s_axi_rresp;
      @(posedge clk);
      #1;
      s_axi_rready = 1'b0;
   endtask

   task automatic expect_csr(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      read_csr(addr, data, resp);
      check(name, data, exp);
      check("s_axi_rresp", resp, AXI_RESP_OKAY);
   endtask

   task automatic check_readbacks();
      expect_csr(CSR_PC, {16'b0, model[REG_PC]}, "pc readback");
      expect_csr(CSR_DR, {16'b0, model[REG_DR]}, "dr readback");
      expect_csr(CSR_AC, {16'b0, model[REG_AC]}, "ac readback");
      expect_csr(CSR_SP, {16'b0, model[REG_SP]}, "sp readback");
   endtask

   // Polls DEPOSIT until the pending bit drops
   task automatic wait_deposit_done(output logic [31:0] word);
      logic [1:0] resp;
      read_csr(CSR_DEPOSIT, word, resp);
      for (int n = 0; word[31]; n++) begin
         if (n == TIMEOUT) fail_now("deposit still pending after the microcode went idle");
         read_csr(CSR_DEPOSIT, word, resp);
      end
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin
      logic [1:0]  resp;
      logic [31:0] word;
      logic [15:0] val;
      logic [15:0] held;
      clk = 1'b0;
      rst_n = 1'b0;
      {raddr, waddr, action, ibus_in} = '0;
      {s_axi_awaddr, s_axi_awvalid, s_axi_wdata, s_axi_wstrb, s_axi_wvalid} = '0;
      {s_axi_bready, s_axi_araddr, s_axi_arvalid, s_axi_rready} = '0;
      lfsr_state = 32'h09db_3a8c;
      num_steps = 0;
      for (int r = 0; r < NUM_REGS; r++) model[r] = 16'h0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check("fz", fz, 1'b1);
      check("ac_neg", ac_neg, 1'b0);
      check("ibus_drive", ibus_drive, 1'b0);
      check("fpd", fpd, 8'h0);
      check("s_axi_bvalid", s_axi_bvalid, 1'b0);
      check("s_axi_rvalid", s_axi_rvalid, 1'b0);
      check_readbacks();
      build_table();                       // Model steps forward from reset
      run_table();
      check_readbacks();
      for (int r = 0; r < NUM_REGS; r++) begin
         for (int h = 0; h < 2; h++) begin
            write_csr(CSR_PANEL_SEL, {29'b0, h[0], r[1:0]}, resp);
            check("s_axi_bresp", resp, AXI_RESP_OKAY);
            check("fpd", fpd, h ? model[r][15:8] : model[r][7:0]);
         end
      end
      for (int r = 0; r < NUM_REGS; r++) begin
         val = rand_bits(16);
         write_csr(CSR_DEPOSIT, {14'b0, r[1:0], val}, resp);
         check("s_axi_bresp", resp, AXI_RESP_OKAY);
         wait_deposit_done(word);
         check("deposit status", word, {16'b0, val} | (r << 16));
         model[r] = val;
      end
      check_readbacks();
      check("ac", ac, model[REG_AC]);
      // Deposit against a register that the microcode keeps writing
      held = rand_bits(16);
      val  = rand_bits(16);
      @(posedge clk);
      #1;
      waddr   = {3'b010, REG_SP};
      ibus_in = held;
      write_csr(CSR_DEPOSIT, {14'b0, REG_SP, val}, resp);
      check("s_axi_bresp", resp, AXI_RESP_OKAY);
      expect_csr(CSR_DEPOSIT, {1'b1, 13'b0, REG_SP, val}, "deposit status");
      expect_csr(CSR_SP, {16'b0, held}, "sp readback");
      write_csr(CSR_DEPOSIT, {14'b0, REG_DR, ~val}, resp);
      check("s_axi_bresp", resp, AXI_RESP_SLVERR);
      @(posedge clk);
      #1;
      waddr = 5'b0;
      wait_deposit_done(word);
      check("deposit status", word, {1'b0, 13'b0, REG_SP, val});
      model[REG_SP] = val;
      check_readbacks();
      expect_csr(5'h18, 32'h0, "unmapped readback");
      expect_csr(5'h1C, 32'h0, "unmapped readback");
      write_csr(CSR_PC, 32'hFFFF_FFFF, resp);
      check("s_axi_bresp", resp, AXI_RESP_OKAY);
      write_csr(CSR_AC, ~{16'b0, model[REG_AC]}, resp);
      check("s_axi_bresp", resp, AXI_RESP_OKAY);
      check_readbacks();
      $display("all tests passed");
      $finish;
   end

endmodule

/* sim.f */
reg_board_pkg.sv
field_decoder.sv
major_register.sv
panel_mux.sv
panel_csr.sv
reg_board_top.sv
tb_reg_board.sv
